/* Makefile */
# Verilator build and run for the chip testbench.

VERILATOR ?= verilator
TOP       ?= tb_chip
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
rtl/chip_pkg.sv
rtl/mbox_fifo.sv
rtl/mbox_channel.sv
rtl/serial_port.sv
rtl/chip.sv
sim/tb_chip.sv

/* rtl/chip.sv */
module chip (
  input  logic                        CPU_CLK,
  input  logic                        RST,            // Synchronous, active low.
  input  logic                        host_wr,
  input  logic                        host_rd,
  input  logic                        host_ctrl_wr,
  input  logic                        host_irq_ack,
  input  logic                        host_err_ack,
  input  logic [chip_pkg::DATA_W-1:0] host_wdata,
  input  logic [chip_pkg::CTRL_W-1:0] host_ctrl_data,
  output logic [chip_pkg::DATA_W-1:0] host_rdata,
  output logic                        host_rx_avail,
  output logic                        host_tx_full,
  output logic                        host_irq,
  output logic                        host_err,
  output logic [chip_pkg::LEN_W-1:0]  host_status,
  input  logic                        eth_wire_rx,
  output logic                        eth_wire_tx
);

  logic [chip_pkg::RST_HOLD_W-1:0] rst_cnt;       // Reset-stretch counter.
  logic                            core_rst;      // Inner reset, active low.

  logic [chip_pkg::DATA_W-1:0] send_data;
  logic [chip_pkg::DATA_W-1:0] recv_data;
  logic [chip_pkg::LEN_W-1:0]  bit_period;
  logic [chip_pkg::LEN_W-1:0]  rx_count;
  logic                        send_avail;
  logic                        send_take;
  logic                        recv_write;
  logic                        irq;
  logic                        err;
  logic                        err_ack;
  logic                        run;

  ////////////////////////////////////////////////////////////
  // Reset stretch.
  ////////////////////////////////////////////////////////////

  assign core_rst = rst_cnt[chip_pkg::RST_HOLD_W-1];  // Top bit releases the core.

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      rst_cnt <= '0;
    end else if (!core_rst) begin
      rst_cnt <= rst_cnt + 1'b1;                     // Freezes once released.
    end
  end

  ////////////////////////////////////////////////////////////
  // Mailbox channel 0 and serial port.
  ////////////////////////////////////////////////////////////

  mbox_channel u_mbox (
    .CPU_CLK        (CPU_CLK),
    .RST            (core_rst),
    .host_wr        (host_wr),
    .host_wdata     (host_wdata),
    .host_rd        (host_rd),
    .host_rdata     (host_rdata),
    .host_rx_avail  (host_rx_avail),
    .host_tx_full   (host_tx_full),
    .host_ctrl_wr   (host_ctrl_wr),
    .host_ctrl_data (host_ctrl_data),
    .host_irq       (host_irq),
    .host_irq_ack   (host_irq_ack),
    .host_err       (host_err),
    .host_err_ack   (host_err_ack),
    .host_status    (host_status),
    .send_data      (send_data),
    .send_avail     (send_avail),
    .send_take      (send_take),
    .recv_data      (recv_data),
    .recv_write     (recv_write),
    .irq            (irq),
    .err            (err),
    .err_ack        (err_ack),
    .run            (run),
    .bit_period     (bit_period),
    .rx_count       (rx_count)
  );

  serial_port u_port (
    .CPU_CLK    (CPU_CLK),
    .RST        (core_rst),
    .run        (run),
    .bit_period (bit_period),
    .send_data  (send_data),
    .send_avail (send_avail),
    .send_take  (send_take),
    .recv_data  (recv_data),
    .recv_write (recv_write),
    .irq        (irq),
    .err        (err),
    .err_ack    (err_ack),
    .rx_count   (rx_count),
    .wire_rx    (eth_wire_rx),
    .wire_tx    (eth_wire_tx)
  );

endmodule

/* rtl/chip_pkg.sv */
package chip_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath widths.
  ////////////////////////////////////////////////////////////

  localparam int unsigned DATA_W = 32;   // Mailbox word and serial payload.
  localparam int unsigned LEN_W  = 24;   // Bit period field and received-word count.
  localparam int unsigned CTRL_W = 25;   // Run enable on top, bit period below.

  ////////////////////////////////////////////////////////////
  // Mailbox queues.
  ////////////////////////////////////////////////////////////

  localparam int unsigned FIFO_DEPTH = 4;  // Words per queue.
  localparam int unsigned FIFO_AW    = 2;  // Pointer width for FIFO_DEPTH.

  ////////////////////////////////////////////////////////////
  // Reset stretch.
  ////////////////////////////////////////////////////////////

  // Inner reset lets go when the top bit of the counter sets,
  // eight cycles after RST rises.
  localparam int unsigned RST_HOLD_W = 4;

endpackage

/* rtl/mbox_channel.sv */
module mbox_channel (
  input  logic                        CPU_CLK,
  input  logic                        RST,             // Synchronous, active low.

  // Host side.
  input  logic                        host_wr,         // Push into send queue.
  input  logic [chip_pkg::DATA_W-1:0] host_wdata,
  input  logic                        host_rd,         // Pop from receive queue.
  output logic [chip_pkg::DATA_W-1:0] host_rdata,      // Receive queue head.
  output logic                        host_rx_avail,
  output logic                        host_tx_full,
  input  logic                        host_ctrl_wr,    // Load control register.
  input  logic [chip_pkg::CTRL_W-1:0] host_ctrl_data,
  output logic                        host_irq,        // Sticky receive flag.
  input  logic                        host_irq_ack,
  output logic                        host_err,        // Sticky stop-bit error.
  input  logic                        host_err_ack,
  output logic [chip_pkg::LEN_W-1:0]  host_status,     // Received-word count.

  // Serial port side.
  output logic [chip_pkg::DATA_W-1:0] send_data,       // Send queue head.
  output logic                        send_avail,
  input  logic                        send_take,       // Pop of send queue.
  input  logic [chip_pkg::DATA_W-1:0] recv_data,
  input  logic                        recv_write,      // Push into receive queue.
  input  logic                        irq,             // Receive pulse.
  input  logic                        err,             // Error level.
  output logic                        err_ack,
  output logic                        run,             // Transmit enable.
  output logic [chip_pkg::LEN_W-1:0]  bit_period,      // Cycles per serial bit.
  input  logic [chip_pkg::LEN_W-1:0]  rx_count
);

  logic [chip_pkg::CTRL_W-1:0] ctrl_q;     // Control register.
  logic                        irq_q;      // Interrupt flag.
  logic                        err_q;      // Error flag.

  ////////////////////////////////////////////////////////////
  // Queues.
  ////////////////////////////////////////////////////////////

  // Host to wire.
  mbox_fifo u_send_fifo (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (host_wr),
    .push_data (host_wdata),
    .pop       (send_take),
    .head      (send_data),
    .not_empty (send_avail),
    .full      (host_tx_full)
  );

  // Wire to host. A word arriving while full is lost inside the queue.
  mbox_fifo u_recv_fifo (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .push      (recv_write),
    .push_data (recv_data),
    .pop       (host_rd),
    .head      (host_rdata),
    .not_empty (host_rx_avail),
    .full      ()
  );

  ////////////////////////////////////////////////////////////
  // Control register and flags.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      ctrl_q <= '0;                        // Port stopped after reset.
    end else if (host_ctrl_wr) begin
      ctrl_q <= host_ctrl_data;            // Takes effect next cycle.
    end
  end

  assign run        = ctrl_q[chip_pkg::CTRL_W-1];       // Top bit.
  assign bit_period = ctrl_q[chip_pkg::LEN_W-1:0];      // Low field.

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      irq_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      if (irq) begin
        irq_q <= 1'b1;                     // A new word beats the ack.
      end else if (host_irq_ack) begin
        irq_q <= 1'b0;
      end
      if (host_err_ack) begin
        err_q <= 1'b0;                     // Port clears its level on the same edge.
      end else if (err) begin
        err_q <= 1'b1;
      end
    end
  end

  assign host_irq    = irq_q;
  assign host_err    = err_q;
  assign err_ack     = host_err_ack;       // Port drops err with the host ack.
  assign host_status = rx_count;

endmodule

/* rtl/mbox_fifo.sv */
module mbox_fifo (
  input  logic                        CPU_CLK,
  input  logic                        RST,        // Synchronous, active low.
  input  logic                        push,       // Write strobe.
  input  logic [chip_pkg::DATA_W-1:0] push_data,
  input  logic                        pop,        // Read strobe.
  output logic [chip_pkg::DATA_W-1:0] head,       // Show-ahead word.
  output logic                        not_empty,
  output logic                        full
);

  logic [chip_pkg::DATA_W-1:0] mem [chip_pkg::FIFO_DEPTH];  // Word storage.
  logic [chip_pkg::FIFO_AW-1:0] wr_ptr;                      // Next slot to write.
  logic [chip_pkg::FIFO_AW-1:0] rd_ptr;                      // Current head slot.
  logic [chip_pkg::FIFO_AW:0]   count;                       // Occupancy, 0 to depth.
  logic                         do_push;
  logic                         do_pop;

  assign do_push   = push && !full;       // Push while full is dropped.
  assign do_pop    = pop && not_empty;    // Pop while empty is ignored.
  assign head      = mem[rd_ptr];         // Head is visible before the pop.
  assign not_empty = (count != '0);
  assign full      = (count == (chip_pkg::FIFO_AW + 1)'(chip_pkg::FIFO_DEPTH));

  // Storage array has no reset.
  always_ff @(posedge CPU_CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;           // Write into the tail slot.
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;                       // Empty after reset.
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;          // Pointers wrap naturally.
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;   // Push only.
        2'b01:   count <= count - 1'b1;   // Pop only.
        default: count <= count;          // Both or neither.
      endcase
    end
  end

endmodule

/* rtl/serial_port.sv */
module serial_port (
  input  logic                        CPU_CLK,
  input  logic                        RST,          // Synchronous, active low.
  input  logic                        run,          // Allows new frames out.
  input  logic [chip_pkg::LEN_W-1:0]  bit_period,   // Cycles per bit.
  input  logic [chip_pkg::DATA_W-1:0] send_data,    // Word to send.
  input  logic                        send_avail,
  output logic                        send_take,    // Pops the send queue.
  output logic [chip_pkg::DATA_W-1:0] recv_data,    // Receive shift register.
  output logic                        recv_write,   // Word complete.
  output logic                        irq,
  output logic                        err,          // Bad stop bit, held.
  input  logic                        err_ack,
  output logic [chip_pkg::LEN_W-1:0]  rx_count,     // Good words received.
  input  logic                        wire_rx,
  output logic                        wire_tx
);

  logic [chip_pkg::LEN_W-1:0]  period_end;   // Last timer value of a bit.
  logic [chip_pkg::LEN_W-1:0]  rx_half;      // Start-bit alignment point.

  // Transmit side.
  logic                         tx_busy;
  logic                         tx_start;
  logic                         tx_tick;      // Bit boundary.
  logic [chip_pkg::LEN_W-1:0]   tx_timer;
  logic [5:0]                   tx_bit;       // 0 start, 1..32 data, 33 stop.
  logic [chip_pkg::DATA_W+1:0]  tx_shift;     // Whole frame, LSB on the wire.

  // Receive side.
  logic                         rx_s1;        // Synchronizer stages.
  logic                         rx_s2;
  logic                         rx_prev;      // Last synchronized level.
  logic                         rx_fall;
  logic                         rx_busy;
  logic                         rx_tick;      // Sample point.
  logic [chip_pkg::LEN_W-1:0]   rx_timer;
  logic [chip_pkg::LEN_W-1:0]   rx_target;
  logic [5:0]                   rx_bit;       // Same numbering as tx_bit.

  assign period_end = bit_period - 1'b1;
  // Two cycles are already lost in the synchronizer.
  assign rx_half    = (bit_period >> 1) - 1'b1;

  ////////////////////////////////////////////////////////////
  // Transmitter.
  ////////////////////////////////////////////////////////////

  assign tx_start = !tx_busy && run && send_avail;      // Only from idle.
  assign tx_tick  = tx_busy && (tx_timer == period_end);

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      tx_busy   <= 1'b0;
      tx_timer  <= '0;
      tx_bit    <= '0;
      send_take <= 1'b0;
    end else begin
      send_take <= tx_start;              // Lines up with the start bit.
      if (tx_start) begin
        tx_busy  <= 1'b1;
        tx_timer <= '0;
        tx_bit   <= '0;
      end else if (tx_tick) begin
        tx_timer <= '0;
        tx_bit   <= tx_bit + 1'b1;
        if (tx_bit == 6'(chip_pkg::DATA_W + 1)) begin
          tx_busy <= 1'b0;                // Stop bit done.
        end
      end else if (tx_busy) begin
        tx_timer <= tx_timer + 1'b1;
      end
    end
  end

  always_ff @(posedge CPU_CLK) begin
    if (tx_start) begin
      tx_shift <= {1'b1, send_data, 1'b0};            // Stop, data, start.
    end else if (tx_tick) begin
      tx_shift <= {1'b1, tx_shift[chip_pkg::DATA_W+1:1]};
    end
  end

  assign wire_tx = tx_busy ? tx_shift[0] : 1'b1;      // Idles high.

  ////////////////////////////////////////////////////////////
  // Receiver.
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= wire_rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  assign rx_fall   = rx_prev && !rx_s2;                 // Start edge.
  assign rx_target = (rx_bit == 6'd0) ? rx_half : period_end;
  assign rx_tick   = rx_busy && (rx_timer == rx_target);

  always_ff @(posedge CPU_CLK) begin
    if (!RST) begin
      rx_busy    <= 1'b0;
      rx_timer   <= '0;
      rx_bit     <= '0;
      recv_write <= 1'b0;
      err        <= 1'b0;
      rx_count   <= '0;
    end else begin
      recv_write <= 1'b0;
      if (err_ack) begin
        err <= 1'b0;
      end
      if (!rx_busy) begin
        rx_timer <= '0;
        rx_bit   <= '0;
        if (rx_fall) begin
          rx_busy <= 1'b1;
        end
      end else if (!rx_tick) begin
        rx_timer <= rx_timer + 1'b1;
      end else begin
        rx_timer <= '0;
        rx_bit   <= rx_bit + 1'b1;
        if (rx_bit == 6'd0) begin
          if (rx_s2) begin
            rx_busy <= 1'b0;              // Glitch, not a start bit.
          end
        end else if (rx_bit == 6'(chip_pkg::DATA_W + 1)) begin
          rx_busy <= 1'b0;
          if (rx_s2) begin
            recv_write <= 1'b1;           // Good frame.
            rx_count   <= rx_count + 1'b1;
          end else begin
            err <= 1'b1;                  // Framing error wins over ack.
          end
        end
      end
    end
  end

  // Data bits arrive LSB first.
  always_ff @(posedge CPU_CLK) begin
    if (rx_tick && (rx_bit != 6'd0) && (rx_bit != 6'(chip_pkg::DATA_W + 1))) begin
      recv_data <= {rx_s2, recv_data[chip_pkg::DATA_W-1:1]};
    end
  end

  assign irq = recv_write;                 // Same pulse as the write.

endmodule

/* sim/tb_chip.sv */
module tb_chip;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BIT_PERIOD  = 4;                 // Cycles per serial bit.
  localparam int WAIT_LIMIT  = 400;               // Well over one frame.
  localparam int GATE_WINDOW = 300;               // Cycles watched with run clear.
  localparam int LOW_HOLD    = 44 * BIT_PERIOD;   // Longer than a whole frame.
  localparam int RX_AVAIL    = 0;                 // Selectors for flag_value.
  localparam int IRQ         = 1;
  localparam int ERR         = 2;

  logic                          CPU_CLK = 1'b0;
  logic                          RST;
  logic                          host_wr, host_rd, host_ctrl_wr;
  logic                          host_irq_ack, host_err_ack;
  logic [chip_pkg::DATA_W-1:0]   host_wdata;
  logic [chip_pkg::CTRL_W-1:0]   host_ctrl_data;
  logic [chip_pkg::DATA_W-1:0]   host_rdata;
  logic                          host_rx_avail, host_tx_full, host_irq, host_err;
  logic [chip_pkg::LEN_W-1:0]    host_status;
  logic                          eth_wire_rx, eth_wire_tx;
  logic                          line_low;        // Pulls the loopback wire low.
  logic                          in_stretch;      // Reset window being checked.
  logic                          gate_closed;     // Wire must stay idle.
  logic [chip_pkg::DATA_W-1:0]   exp_q[$];        // Words expected back, in order.
  logic [chip_pkg::LEN_W-1:0]    status_before;
  int check_fails = 0, stretch_fails = 0, gate_fails = 0, timeouts = 0;
  int tests_run = 0, tests_bad = 0;

  always #20 CPU_CLK = ~CPU_CLK;                  // 40 ns period.

  assign eth_wire_rx = line_low ? 1'b0 : eth_wire_tx;   // Loopback.

  chip u_chip (
    .CPU_CLK (CPU_CLK), .RST (RST),
    .host_wr (host_wr), .host_rd (host_rd), .host_ctrl_wr (host_ctrl_wr),
    .host_irq_ack (host_irq_ack), .host_err_ack (host_err_ack),
    .host_wdata (host_wdata), .host_ctrl_data (host_ctrl_data),
    .host_rdata (host_rdata), .host_rx_avail (host_rx_avail),
    .host_tx_full (host_tx_full), .host_irq (host_irq), .host_err (host_err),
    .host_status (host_status),
    .eth_wire_rx (eth_wire_rx), .eth_wire_tx (eth_wire_tx)
  );

  ////////////////////////////////////////////////////////////
  // Checks that run every clock.
  ////////////////////////////////////////////////////////////

  assert property (@(posedge CPU_CLK) in_stretch |-> (eth_wire_tx && !host_irq && !host_err
      && !host_rx_avail && !host_tx_full && host_status == '0))
    else begin
      $display("FAILED %0t ns: outputs active during reset stretch", $time);
      stretch_fails++;
    end

  assert property (@(posedge CPU_CLK) gate_closed |-> eth_wire_tx)
    else begin
      $display("FAILED %0t ns: eth_wire_tx left idle with run clear", $time);
      gate_fails++;
    end

  ////////////////////////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////////////////////////

  function automatic int total_fails();
    return check_fails + stretch_fails + gate_fails + timeouts;
  endfunction

  function automatic logic flag_value(input int which);
    case (which)
      RX_AVAIL: return host_rx_avail;
      IRQ:      return host_irq;
      default:  return host_err;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                             input string what);
    assert (got == want)
      else begin
        $display("FAILED %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
        check_fails++;
      end
  endtask

  // Polls at the falling edge, where outputs are settled.
  task automatic wait_flag(input int which, input logic level, input string what);
    int n;
    n = 0;
    @(negedge CPU_CLK);
    while (flag_value(which) != level && n < WAIT_LIMIT) begin
      @(negedge CPU_CLK);
      n++;
    end
    if (flag_value(which) != level) begin
      $display("Timeout: %s did not reach %0b within %0d cycles", what, level, WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic write_ctrl(input logic run, input int period);
    @(posedge CPU_CLK);
    host_ctrl_wr   <= 1'b1;
    host_ctrl_data <= {run, (chip_pkg::LEN_W)'(period)};   // Run on top.
    @(posedge CPU_CLK);
    host_ctrl_wr   <= 1'b0;
  endtask

  task automatic send_queued();
    foreach (exp_q[i]) begin
      @(posedge CPU_CLK);
      host_wr    <= 1'b1;                         // Back to back.
      host_wdata <= exp_q[i];
    end
    @(posedge CPU_CLK);
    host_wr <= 1'b0;
  endtask

  task automatic pulse_ack(input int which);
    @(posedge CPU_CLK);
    if (which == IRQ) host_irq_ack <= 1'b1;
    else host_err_ack <= 1'b1;
    @(posedge CPU_CLK);
    host_irq_ack <= 1'b0;
    host_err_ack <= 1'b0;
  endtask

  task automatic receive_word();
    logic [31:0] want;
    want = exp_q.pop_front();
    wait_flag(RX_AVAIL, 1'b1, "host_rx_avail");
    check_value(host_rdata, want, "host_rdata");
    @(posedge CPU_CLK);
    host_rd <= 1'b1;                              // Pop the head.
    @(posedge CPU_CLK);
    host_rd <= 1'b0;
  endtask

  task automatic end_test(input string name, input int fails_before);
    int fails;
    fails = total_fails() - fails_before;
    tests_run++;
    if (fails != 0) tests_bad++;
    $display("[%0d] %s: %s (%0d errors)", tests_run, name, (fails == 0) ? "ok" : "FAIL", fails);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus.
  ////////////////////////////////////////////////////////////

  initial begin
    int base;
    void'($urandom(32'h2045_ce3f));
    RST            <= 1'b0;
    host_wr        <= 1'b0;
    host_rd        <= 1'b0;
    host_ctrl_wr   <= 1'b0;
    host_irq_ack   <= 1'b0;
    host_err_ack   <= 1'b0;
    host_wdata     <= '0;
    host_ctrl_data <= '0;
    line_low       <= 1'b0;
    in_stretch     <= 1'b0;
    gate_closed    <= 1'b0;

    base = total_fails();
    repeat (2) @(posedge CPU_CLK);
    in_stretch     <= 1'b1;
    host_wr        <= 1'b1;                       // Pushes and a run load held in reset.
    host_wdata     <= $urandom;
    host_ctrl_wr   <= 1'b1;
    host_ctrl_data <= {1'b1, (chip_pkg::LEN_W)'(BIT_PERIOD)};
    repeat (3) @(posedge CPU_CLK);                // Five cycles with RST low.
    RST <= 1'b1;
    repeat (8) @(posedge CPU_CLK);
    in_stretch   <= 1'b0;
    host_wr      <= 1'b0;
    host_ctrl_wr <= 1'b0;
    @(negedge CPU_CLK);
    end_test("reset stretch", base);

    base = total_fails();
    write_ctrl(1'b1, BIT_PERIOD);
    exp_q.push_back($urandom);
    send_queued();
    wait_flag(RX_AVAIL, 1'b1, "host_rx_avail");
    check_value(32'(host_irq), 32'd1, "host_irq");
    check_value(32'(host_status), 32'd1, "host_status");
    receive_word();
    pulse_ack(IRQ);
    wait_flag(IRQ, 1'b0, "host_irq");
    end_test("single word loopback", base);

    base = total_fails();
    repeat (4) exp_q.push_back($urandom);
    send_queued();
    repeat (4) receive_word();
    @(negedge CPU_CLK);
    check_value(32'(host_status), 32'd5, "host_status");
    pulse_ack(IRQ);
    end_test("burst order", base);

    base = total_fails();
    write_ctrl(1'b0, BIT_PERIOD);
    exp_q.push_back($urandom);
    send_queued();
    @(posedge CPU_CLK);
    gate_closed <= 1'b1;
    repeat (GATE_WINDOW) @(posedge CPU_CLK);
    gate_closed <= 1'b0;
    @(negedge CPU_CLK);
    check_value(32'(host_rx_avail), 32'd0, "host_rx_avail");
    write_ctrl(1'b1, BIT_PERIOD);                 // Queued word goes out now.
    receive_word();
    end_test("run gate", base);

    base = total_fails();
    status_before = (chip_pkg::LEN_W)'(6);        // One, four and one good words so far.
    @(posedge CPU_CLK);
    line_low <= 1'b1;                             // Frame of zeros, bad stop bit.
    repeat (LOW_HOLD) @(posedge CPU_CLK);
    line_low <= 1'b0;
    wait_flag(ERR, 1'b1, "host_err");
    check_value(32'(host_rx_avail), 32'd0, "host_rx_avail");
    check_value(32'(host_status), 32'(status_before), "host_status");
    pulse_ack(ERR);
    wait_flag(ERR, 1'b0, "host_err");
    exp_q.push_back($urandom);
    send_queued();
    receive_word();
    @(negedge CPU_CLK);
    check_value(32'(host_status), 32'(status_before) + 32'd1, "host_status");
    end_test("stop-bit error", base);

    $display("Tests run %0d, with errors %0d, failed checks %0d, timeouts %0d",
             tests_run, tests_bad, check_fails + stretch_fails + gate_fails, timeouts);
    if (total_fails() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
